// File: hw/video_format_pkg.sv
// video stream format definitions
// pixel and channel layout, frame sizes and packet type codes
`default_nettype none

package video_format_pkg;

   // colour channel layout
   localparam int chan_w    = 8;
   localparam int num_chans = 3;

   // channel 0 sits in the low byte of the beat
   typedef logic [num_chans-1:0][chan_w-1:0] pixel_t;

   // one extra bit per channel holds the carry of a two-pixel sum
   typedef logic [num_chans-1:0][chan_w:0] pair_sum_t;

   // input frame, kept small
   localparam int in_width  = 32;
   localparam int in_height = 8;

   // output frame, 16 bits wide so the control packet can take nibbles from it
   localparam logic [15:0] out_width  = 16'(in_width / 2);
   localparam logic [15:0] out_height = 16'(in_height / 2);

   // low nibble of the first beat of a packet
   localparam logic [3:0] pkt_type_video = 4'h0;
   localparam logic [3:0] pkt_type_ctrl  = 4'hF;

endpackage

`default_nettype wire

// File: hw/halver_pkg.sv
// size halver internal types
// controller states, output beat opcodes and raster position types
`default_nettype none

package halver_pkg;

   typedef enum logic [1:0] {
      st_idle,
      st_ctrl_pkt,
      st_vid_hdr,
      st_stream
   } ctrl_state_t;

   // what the output register loads on the next edge
   typedef enum logic [2:0] {
      op_none,
      op_ctrl_0,
      op_ctrl_1,
      op_ctrl_2,
      op_ctrl_3,
      op_vid_hdr,
      op_pixel,
      op_pixel_last
   } beat_op_t;

   // input raster position
   typedef logic [$clog2(video_format_pkg::in_width)-1:0]  col_t;
   typedef logic [$clog2(video_format_pkg::in_height)-1:0] row_t;

endpackage

`default_nettype wire

// File: hw/halver_ctrl.sv
// size halver controller
// detects video packets, sequences the control packet and header,
// and paces the sink against the output register
`default_nettype none

module halver_ctrl (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 din_valid,
   input  logic                 din_startofpacket,
   input  logic                 din_endofpacket,
   input  logic [3:0]           din_type,
   output logic                 din_ready,
   input  logic                 slot_free,
   input  logic                 in_last,
   input  logic                 avg_valid,
   output halver_pkg::beat_op_t beat_op,
   output logic                 pix_take,
   output logic                 frame_start
);

   import video_format_pkg::*;
   import halver_pkg::*;

   ctrl_state_t state;
   ctrl_state_t next_state;
   logic [1:0]  ctrl_cnt;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state    <= st_idle;
         ctrl_cnt <= 2'd0;
      end
      else
      begin
         state <= next_state;
         // wraps back to zero after the fourth control beat
         if (state == st_ctrl_pkt && slot_free)
         begin
            ctrl_cnt <= ctrl_cnt + 2'd1;
         end
      end
   end

   always_comb
   begin
      next_state  = state;
      beat_op     = op_none;
      din_ready   = 1'b0;
      pix_take    = 1'b0;
      frame_start = 1'b0;
      case (state)
         st_idle:
         begin
            // swallow everything until a video packet starts
            din_ready = 1'b1;
            if (din_valid && din_startofpacket && din_type == pkt_type_video)
            begin
               frame_start = 1'b1;
               next_state  = st_ctrl_pkt;
            end
         end
         st_ctrl_pkt:
         begin
            if (slot_free)
            begin
               case (ctrl_cnt)
                  2'd0: beat_op = op_ctrl_0;
                  2'd1: beat_op = op_ctrl_1;
                  2'd2: beat_op = op_ctrl_2;
                  default:
                  begin
                     beat_op    = op_ctrl_3;
                     next_state = st_vid_hdr;
                  end
               endcase
            end
         end
         st_vid_hdr:
         begin
            if (slot_free)
            begin
               beat_op    = op_vid_hdr;
               next_state = st_stream;
            end
         end
         st_stream:
         begin
            // a pixel is only taken when its result has somewhere to go
            din_ready = slot_free;
            pix_take  = din_valid && slot_free;
            if (pix_take && in_last)
            begin
               beat_op    = op_pixel_last;
               next_state = st_idle;
            end
            else if (avg_valid)
            begin
               beat_op = op_pixel;
            end
         end
         default:
         begin
            next_state = st_idle;
         end
      endcase
   end

   // input end of packet must line up with the raster position
   eop_on_last_pixel: assert property (@(posedge clk) disable iff (reset)
      (state == st_stream && pix_take && din_endofpacket) |-> in_last);

endmodule

`default_nettype wire

// File: hw/raster_counter.sv
// raster counter
// tracks column and row of the accepted input pixel stream
`default_nettype none

module raster_counter (
   input  logic             clk,
   input  logic             reset,
   input  logic             frame_start,
   input  logic             pix_take,
   output halver_pkg::col_t col,
   output halver_pkg::row_t row,
   output logic             in_last
);

   import video_format_pkg::*;
   import halver_pkg::*;

   logic at_last_col;
   logic at_last_row;

   assign at_last_col = (col == col_t'(in_width - 1));
   assign at_last_row = (row == row_t'(in_height - 1));
   assign in_last     = at_last_col && at_last_row;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         col <= '0;
         row <= '0;
      end
      else if (frame_start)
      begin
         col <= '0;
         row <= '0;
      end
      else if (pix_take)
      begin
         if (at_last_col)
         begin
            col <= '0;
            row <= at_last_row ? '0 : row + row_t'(1);
         end
         else
         begin
            col <= col + col_t'(1);
         end
      end
   end

   // once the last row is done, no pixel arrives before a new frame header
   no_row_overrun: assert property (@(posedge clk) disable iff (reset)
      (pix_take && in_last) |=> !pix_take);

endmodule

`default_nettype wire

// File: hw/pixel_averager.sv
// 2x2 pixel averager
// pairs pixels horizontally, buffers the even-row pair sums and
// averages each colour channel over the block on the odd row
`default_nettype none

module pixel_averager (
   input  logic                     clk,
   input  logic                     pix_take,
   input  video_format_pkg::pixel_t din_data,
   input  halver_pkg::col_t         col,
   input  halver_pkg::row_t         row,
   output logic                     avg_valid,
   output video_format_pkg::pixel_t avg_pixel
);

   import video_format_pkg::*;
   import halver_pkg::*;

   pixel_t    first_pix;
   pair_sum_t pair_sum;
   pair_sum_t line_buf [out_width];
   logic [$bits(col_t)-2:0] pair_idx;
   logic [num_chans-1:0][chan_w+1:0] quad_sum;

   // one buffer entry per horizontal pair
   assign pair_idx = col[$bits(col_t)-1:1];

   // left pixel of the current pair
   always_ff @(posedge clk)
   begin
      if (pix_take && !col[0])
      begin
         first_pix <= din_data;
      end
   end

   always_comb
   begin
      for (int c = 0; c < num_chans; c++)
      begin
         pair_sum[c] = {1'b0, first_pix[c]} + {1'b0, din_data[c]};
      end
   end

   // even rows leave their pair sums for the row below
   always_ff @(posedge clk)
   begin
      if (pix_take && col[0] && !row[0])
      begin
         line_buf[pair_idx] <= pair_sum;
      end
   end

   // each channel summed on its own, so no carry crosses into a neighbour
   always_comb
   begin
      for (int c = 0; c < num_chans; c++)
      begin
         quad_sum[c]  = {1'b0, line_buf[pair_idx][c]} + {1'b0, pair_sum[c]};
         avg_pixel[c] = quad_sum[c][chan_w+1:2];
      end
   end

   // right pixel of an odd row closes the block
   assign avg_valid = pix_take && col[0] && row[0];

endmodule

`default_nettype wire

// File: hw/packet_source.sv
// output packet register
// holds one source beat and formats control, header and pixel data
`default_nettype none

module packet_source (
   input  logic                     clk,
   input  logic                     reset,
   input  halver_pkg::beat_op_t     beat_op,
   input  video_format_pkg::pixel_t avg_pixel,
   input  logic                     dout_ready,
   output logic                     slot_free,
   output video_format_pkg::pixel_t dout_data,
   output logic                     dout_valid,
   output logic                     dout_startofpacket,
   output logic                     dout_endofpacket
);

   import video_format_pkg::*;
   import halver_pkg::*;

   // empty, or the beat in it leaves on this edge
   assign slot_free = !dout_valid || dout_ready;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         dout_valid         <= 1'b0;
         dout_startofpacket <= 1'b0;
         dout_endofpacket   <= 1'b0;
      end
      else if (slot_free)
      begin
         dout_valid         <= (beat_op != op_none);
         dout_startofpacket <= (beat_op == op_ctrl_0) || (beat_op == op_vid_hdr);
         dout_endofpacket   <= (beat_op == op_ctrl_3) || (beat_op == op_pixel_last);
      end
   end

   // control fields go out one nibble per byte
   always_ff @(posedge clk)
   begin
      if (slot_free && beat_op != op_none)
      begin
         case (beat_op)
            op_ctrl_0:  dout_data <= {20'h0, pkt_type_ctrl};
            op_ctrl_1:  dout_data <= {4'h0, out_width[7:4], 4'h0, out_width[11:8],
                                      4'h0, out_width[15:12]};
            op_ctrl_2:  dout_data <= {4'h0, out_height[11:8], 4'h0, out_height[15:12],
                                      4'h0, out_width[3:0]};
            // 3 is the progressive interlace code
            op_ctrl_3:  dout_data <= {4'h0, 4'h3, 4'h0, out_height[3:0],
                                      4'h0, out_height[7:4]};
            op_vid_hdr: dout_data <= {20'h0, pkt_type_video};
            default:    dout_data <= avg_pixel;
         endcase
      end
   end

   stall_holds_beat: assert property (@(posedge clk) disable iff (reset)
      (dout_valid && !dout_ready) |=> ($stable(dout_data) && dout_valid
         && $stable(dout_startofpacket) && $stable(dout_endofpacket)));

endmodule

`default_nettype wire

// File: hw/halver_top.sv
// video size halver top level
// connects the controller, raster counter, averager and output register
`default_nettype none

module halver_top (
   input  logic                     clk,
   input  logic                     reset,
   input  video_format_pkg::pixel_t din_data,
   input  logic                     din_valid,
   input  logic                     din_startofpacket,
   input  logic                     din_endofpacket,
   output logic                     din_ready,
   output video_format_pkg::pixel_t dout_data,
   output logic                     dout_valid,
   output logic                     dout_startofpacket,
   output logic                     dout_endofpacket,
   input  logic                     dout_ready
);

   import video_format_pkg::*;
   import halver_pkg::*;

   beat_op_t beat_op;
   col_t     col;
   row_t     row;
   pixel_t   avg_pixel;
   logic     slot_free;
   logic     pix_take;
   logic     frame_start;
   logic     in_last;
   logic     avg_valid;

   halver_ctrl ctrl_i (
      .clk               (clk),
      .reset             (reset),
      .din_valid         (din_valid),
      .din_startofpacket (din_startofpacket),
      .din_endofpacket   (din_endofpacket),
      .din_type          (din_data[0][3:0]),
      .din_ready         (din_ready),
      .slot_free         (slot_free),
      .in_last           (in_last),
      .avg_valid         (avg_valid),
      .beat_op           (beat_op),
      .pix_take          (pix_take),
      .frame_start       (frame_start)
   );

   raster_counter raster_i (
      .clk         (clk),
      .reset       (reset),
      .frame_start (frame_start),
      .pix_take    (pix_take),
      .col         (col),
      .row         (row),
      .in_last     (in_last)
   );

   pixel_averager avg_i (
      .clk       (clk),
      .pix_take  (pix_take),
      .din_data  (din_data),
      .col       (col),
      .row       (row),
      .avg_valid (avg_valid),
      .avg_pixel (avg_pixel)
   );

   packet_source source_i (
      .clk                (clk),
      .reset              (reset),
      .beat_op            (beat_op),
      .avg_pixel          (avg_pixel),
      .dout_ready         (dout_ready),
      .slot_free          (slot_free),
      .dout_data          (dout_data),
      .dout_valid         (dout_valid),
      .dout_startofpacket (dout_startofpacket),
      .dout_endofpacket   (dout_endofpacket)
   );

endmodule

`default_nettype wire

// File: tb/tb_halver.sv
// testbench for the video size halver
// applies a table of packets and checks every output beat against a model
`default_nettype none

module tb_halver;

   import video_format_pkg::*;

   typedef struct packed {
      logic [3:0] pkt_type;
      logic       gaps;
      logic       stall;
   } entry_t;

   localparam int          num_entries  = 6;
   localparam int          beat_timeout = 2000;
   localparam logic [31:0] seed         = 32'd15394;

   // non-video packets before the stalled frames, the last frames run back to back
   localparam entry_t stim_tab [num_entries] = '{
      '{pkt_type_video, 1'b0, 1'b0},
      '{pkt_type_ctrl,  1'b0, 1'b0},
      '{4'h7,           1'b1, 1'b0},
      '{pkt_type_video, 1'b1, 1'b1},
      '{pkt_type_video, 1'b0, 1'b1},
      '{pkt_type_video, 1'b0, 1'b0}
   };

   logic        clk;
   logic        reset;
   pixel_t      din_data;
   logic        din_valid;
   logic        din_startofpacket;
   logic        din_endofpacket;
   logic        din_ready;
   pixel_t      dout_data;
   logic        dout_valid;
   logic        dout_startofpacket;
   logic        dout_endofpacket;
   logic        dout_ready;
   pixel_t      frame_pix [num_entries][in_height][in_width];
   pixel_t      got_data [$];
   logic        got_sop [$];
   logic        got_eop [$];
   logic [31:0] stim_rng;
   logic [31:0] stall_rng;
   logic        stall_on;
   logic        aborted;
   int          rd_idx;
   int          mismatch_errs;
   int          timeout_errs;
   int          other_errs;

   halver_top dut_i (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // control field layout, one nibble in the low half of each byte
   function automatic pixel_t nibble_bytes(input logic [3:0] hi, input logic [3:0] mid,
                                           input logic [3:0] lo);
      return {4'h0, hi, 4'h0, mid, 4'h0, lo};
   endfunction

   // truncated mean of one 2x2 block, channel by channel
   function automatic pixel_t block_average(input int e, input int r, input int c);
      pixel_t res;
      int     sum;
      for (int k = 0; k < num_chans; k++)
      begin
         sum = int'(frame_pix[e][2*r][2*c][k]) + int'(frame_pix[e][2*r][2*c+1][k])
             + int'(frame_pix[e][2*r+1][2*c][k]) + int'(frame_pix[e][2*r+1][2*c+1][k]);
         res[k] = 8'(sum / 4);
      end
      return res;
   endfunction

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   // output back-pressure, random only while the current entry asks for it
   initial
   begin
      dout_ready = 1'b0;
      stall_rng  = xorshift(seed ^ 32'h9e3779b9);
      forever
      begin
         @(negedge clk);
         stall_rng  = xorshift(stall_rng);
         dout_ready = !stall_on || (stall_rng[1:0] != 2'd0);
      end
   end

   // output monitor
   always @(posedge clk)
   begin
      if (!reset && dout_valid && dout_ready)
      begin
         got_data.push_back(dout_data);
         got_sop.push_back(dout_startofpacket);
         got_eop.push_back(dout_endofpacket);
      end
   end

   task automatic send_beat(input pixel_t data, input logic sop, input logic eop,
                            input logic gaps);
      int   waited;
      logic taken;
      waited = 0;
      taken  = 1'b0;
      @(negedge clk);
      stim_rng = xorshift(stim_rng);
      if (gaps && stim_rng[2])
      begin
         din_valid = 1'b0;
         repeat (int'(stim_rng[1:0]) + 1) @(negedge clk);
      end
      din_data          = data;
      din_valid         = 1'b1;
      din_startofpacket = sop;
      din_endofpacket   = eop;
      while (!taken && waited < beat_timeout)
      begin
         @(posedge clk);
         taken = din_ready;
         waited++;
      end
      if (!taken)
      begin
         $display("timeout at %0t: the sink did not take an input beat", $time);
         timeout_errs++;
         aborted = 1'b1;
      end
   endtask

   task automatic send_packet(input int e);
      pixel_t hdr;
      stim_rng = xorshift(stim_rng);
      hdr      = {stim_rng[23:4], stim_tab[e].pkt_type};
      send_beat(hdr, 1'b1, 1'b0, stim_tab[e].gaps);
      if (stim_tab[e].pkt_type == pkt_type_video)
      begin
         for (int r = 0; r < in_height && !aborted; r++)
            for (int c = 0; c < in_width && !aborted; c++)
               send_beat(frame_pix[e][r][c], 1'b0,
                         (r == in_height - 1) && (c == in_width - 1), stim_tab[e].gaps);
      end
      else
      begin
         for (int i = 0; i < 4 && !aborted; i++)
            send_beat(frame_pix[e][0][i], 1'b0, i == 3, stim_tab[e].gaps);
      end
   endtask

   task automatic wait_for_beat(output logic ok);
      int waited;
      waited = 0;
      ok     = 1'b0;
      if (!aborted)
      begin
         while (got_data.size() <= rd_idx && waited < beat_timeout)
         begin
            @(negedge clk);
            waited++;
         end
         if (got_data.size() > rd_idx)
            ok = 1'b1;
         else
         begin
            $display("timeout at %0t: output beat %0d never arrived", $time, rd_idx);
            timeout_errs++;
            aborted = 1'b1;
         end
      end
   endtask

   task automatic check_ctrl_beat(input pixel_t exp_data, input logic exp_sop,
                                  input logic exp_eop);
      logic ok;
      wait_for_beat(ok);
      if (ok && (got_data[rd_idx] !== exp_data || got_sop[rd_idx] !== exp_sop
                 || got_eop[rd_idx] !== exp_eop))
      begin
         $display("MISMATCH at %0t: control beat %06h sop %b eop %b, expected %06h sop %b eop %b",
                  $time, got_data[rd_idx], got_sop[rd_idx], got_eop[rd_idx],
                  exp_data, exp_sop, exp_eop);
         mismatch_errs++;
      end
      if (ok)
         rd_idx++;
   endtask

   task automatic check_pixel(input pixel_t exp_data, input logic exp_eop);
      logic ok;
      wait_for_beat(ok);
      if (ok && (got_data[rd_idx] !== exp_data || got_sop[rd_idx] !== 1'b0
                 || got_eop[rd_idx] !== exp_eop))
      begin
         $display("MISMATCH at %0t: pixel beat %06h sop %b eop %b, expected %06h sop 0 eop %b",
                  $time, got_data[rd_idx], got_sop[rd_idx], got_eop[rd_idx],
                  exp_data, exp_eop);
         mismatch_errs++;
      end
      if (ok)
         rd_idx++;
   endtask

   // control packet for the halved size, video header, then the averaged raster
   task automatic check_frame(input int e);
      logic [15:0] w;
      logic [15:0] h;
      w = 16'(in_width / 2);
      h = 16'(in_height / 2);
      check_ctrl_beat(24'h00000F, 1'b1, 1'b0);
      check_ctrl_beat(nibble_bytes(w[7:4], w[11:8], w[15:12]), 1'b0, 1'b0);
      check_ctrl_beat(nibble_bytes(h[11:8], h[15:12], w[3:0]), 1'b0, 1'b0);
      check_ctrl_beat(nibble_bytes(4'h3, h[3:0], h[7:4]), 1'b0, 1'b1);
      check_ctrl_beat(24'h000000, 1'b1, 1'b0);
      for (int r = 0; r < in_height / 2; r++)
         for (int c = 0; c < in_width / 2; c++)
            check_pixel(block_average(e, r, c),
                        (r == in_height / 2 - 1) && (c == in_width / 2 - 1));
   endtask

   task automatic finish_run();
      $display("errors: %0d mismatch, %0d timeout, %0d other",
               mismatch_errs, timeout_errs, other_errs);
      if (mismatch_errs + timeout_errs + other_errs == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   endtask

   initial
   begin
      reset             = 1'b1;
      din_data          = '0;
      din_valid         = 1'b0;
      din_startofpacket = 1'b0;
      din_endofpacket   = 1'b0;
      stall_on          = 1'b0;
      aborted           = 1'b0;
      stim_rng          = seed;
      rd_idx            = 0;
      mismatch_errs     = 0;
      timeout_errs      = 0;
      other_errs        = 0;
      // frames built up front so the driver and the model share them
      for (int e = 0; e < num_entries; e++)
         for (int r = 0; r < in_height; r++)
            for (int c = 0; c < in_width; c++)
            begin
               stim_rng           = xorshift(stim_rng);
               frame_pix[e][r][c] = stim_rng[23:0];
            end
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      // idle output while nothing is sent
      repeat (20)
      begin
         @(posedge clk);
         if (dout_valid)
         begin
            $display("output went valid at %0t before any video packet was sent", $time);
            other_errs++;
         end
      end
      fork
         begin
            for (int e = 0; e < num_entries && !aborted; e++)
            begin
               stall_on = stim_tab[e].stall;
               send_packet(e);
            end
            @(negedge clk);
            din_valid         = 1'b0;
            din_startofpacket = 1'b0;
            din_endofpacket   = 1'b0;
         end
         begin
            for (int e = 0; e < num_entries; e++)
               if (stim_tab[e].pkt_type == pkt_type_video)
                  check_frame(e);
         end
      join
      @(posedge clk);
      stall_on = 1'b0;
      repeat (50) @(posedge clk);
      // beats left over came from nowhere in the model
      if (!aborted && got_data.size() != rd_idx)
      begin
         $display("%0d output beats arrived that no packet should produce",
                  got_data.size() - rd_idx);
         other_errs++;
      end
      finish_run();
   end

endmodule

`default_nettype wire

// File: sources.f
hw/video_format_pkg.sv
hw/halver_pkg.sv
hw/halver_ctrl.sv
hw/raster_counter.sv
hw/pixel_averager.sv
hw/packet_source.sv
hw/halver_top.sv
tb/tb_halver.sv

// File: run_sim.sh
#!/bin/sh
# builds the size halver testbench with Verilator and runs it
# the run fails when the log holds the fail message or no pass message

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_halver -o tb_halver \
   && ./obj_dir/tb_halver > sim.log 2>&1 \
   || { echo "build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
